//--- verilog/dcache_pkg.sv
// ##########################################################################
// data cache shared definitions
// geometry of the 8 KB two-way cache, address, line and tag types,
// and the controller state encoding
// ##########################################################################

package dcache_pkg;

    localparam int OFFSET_W = 4;    // 16-byte lines
    localparam int INDEX_W  = 8;    // 256 sets
    localparam int TAG_W    = 20;
    localparam int WAYS     = 2;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // word 0 sits in bits 31:0
    typedef logic [127:0] line_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE,
        MISS,
        WRITEBACK,
        REFILL,
        UNCACHED
    } cache_state_t;

endpackage

//--- verilog/cache_ram.sv
// ##########################################################################
// single-port synchronous RAM with registered read
// one entry per cache set, payload chosen by type parameter
// ##########################################################################

`timescale 1ns/1ps

module cache_ram
    import dcache_pkg::*;
#(
    parameter type payload_t = line_t
) (
    input  logic               clk,
    input  logic               we,
    input  logic [INDEX_W-1:0] addr,
    input  payload_t           wdata,
    output payload_t           rdata
);

    payload_t mem [0:(1<<INDEX_W)-1];

    // read returns the old contents on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- verilog/dcache.sv
// ##########################################################################
// two-way set-associative write-back data cache controller
// request buffer, segment decode, hit compare, store merge, LRU and
// dirty tracking, miss, writeback and uncached sequencing
// ##########################################################################

`timescale 1ns/1ps

module dcache
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    // cpu side
    input  logic  d_valid,
    input  logic  d_op,
    input  addr_t d_addr,
    input  word_t d_wdata,
    input  strb_t d_wstrb,
    output logic  d_addr_ok,
    output logic  d_data_ok,
    output word_t d_rdata,
    // read path
    output logic  rd_req,
    output addr_t rd_addr,
    output logic  rd_line,
    input  logic  rd_ack,
    input  line_t rd_data,
    // write path
    output logic  wb_req,
    output addr_t wb_addr,
    output logic  wb_line,
    output line_t wb_data,
    output strb_t wb_strb,
    input  logic  wb_ack
);

    cache_state_t state;

    logic               init_busy;
    logic [INDEX_W-1:0] init_cnt;

    logic  req_op;
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_wstrb;

    addr_t              paddr;
    logic               uncached;
    logic               accept;
    logic [INDEX_W-1:0] idx;
    logic [INDEX_W-1:0] ram_index;
    logic [1:0]         word_sel;

    tag_entry_t tag_rd [WAYS];
    line_t      line_rd [WAYS];
    tag_entry_t tag_wdata;
    line_t      data_wdata;
    logic [WAYS-1:0] tag_we;
    logic [WAYS-1:0] data_we;

    logic [WAYS-1:0] hit_way;
    logic            hit;
    line_t           hit_line;
    word_t           hit_word;
    line_t           merged_line;

    logic [WAYS-1:0] pick_oh;
    logic [WAYS-1:0] victim_oh;
    tag_entry_t      victim_tag;
    line_t           victim_line;
    logic            refill_we;

    logic [(1<<INDEX_W)-1:0] lru;     // set bit means way 1 goes next
    logic [WAYS-1:0]         dirty [1<<INDEX_W];

    logic  unc_done;
    word_t unc_rdata;

    assign d_addr_ok = (state == IDLE && !init_busy) || (state == LOOKUP && hit && !req_op);
    assign accept    = d_valid && d_addr_ok;
    assign idx       = req_addr[OFFSET_W +: INDEX_W];
    assign word_sel  = req_addr[OFFSET_W-1:2];

    // kseg0 cached, kseg1 uncached, both drop the top three bits
    always_comb begin
        paddr    = req_addr;
        uncached = 1'b0;
        if (req_addr[31:29] == 3'b100) begin
            paddr = {3'b000, req_addr[28:0]};
        end else if (req_addr[31:29] == 3'b101) begin
            paddr    = {3'b000, req_addr[28:0]};
            uncached = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op    <= d_op;
            req_addr  <= d_addr;
            req_wdata <= d_wdata;
            req_wstrb <= d_wstrb;
        end
    end

    // new set is read in the accepting cycle so a hit answers next cycle
    always_comb begin
        if (init_busy) begin
            ram_index = init_cnt;
        end else if (accept) begin
            ram_index = d_addr[OFFSET_W +: INDEX_W];
        end else begin
            ram_index = idx;
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        cache_ram #(.payload_t(tag_entry_t)) u_tag (
            .clk   (clk),
            .we    (tag_we[w]),
            .addr  (ram_index),
            .wdata (tag_wdata),
            .rdata (tag_rd[w])
        );

        cache_ram #(.payload_t(line_t)) u_data (
            .clk   (clk),
            .we    (data_we[w]),
            .addr  (ram_index),
            .wdata (data_wdata),
            .rdata (line_rd[w])
        );
    end

    always_comb begin
        hit_line    = '0;
        victim_tag  = '0;
        victim_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = tag_rd[w].valid && !uncached &&
                         (tag_rd[w].tag == paddr[31 -: TAG_W]);
            if (hit_way[w]) begin
                hit_line = line_rd[w];
            end
            if (victim_oh[w]) begin
                victim_tag  = tag_rd[w];
                victim_line = line_rd[w];
            end
        end
    end

    assign hit      = |hit_way;
    assign hit_word = hit_line[32*word_sel +: 32];

    // store bytes go over the hit line, written during WRITE
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < 4; b++) begin
            if (req_wstrb[b]) begin
                merged_line[32*word_sel + 8*b +: 8] = req_wdata[8*b +: 8];
            end
        end
    end

    // invalid way first, then LRU
    always_comb begin
        if (!tag_rd[0].valid) begin
            pick_oh = 2'b01;
        end else if (!tag_rd[1].valid) begin
            pick_oh = 2'b10;
        end else if (lru[idx]) begin
            pick_oh = 2'b10;
        end else begin
            pick_oh = 2'b01;
        end
    end

    assign refill_we = (state == REFILL) && rd_req && rd_ack;

    always_comb begin
        tag_wdata.valid = !init_busy;
        tag_wdata.tag   = init_busy ? '0 : paddr[31 -: TAG_W];
    end

    assign data_wdata = (state == WRITE) ? merged_line : rd_data;
    assign tag_we     = {WAYS{init_busy}} | ({WAYS{refill_we}} & victim_oh);
    assign data_we    = ({WAYS{refill_we}} & victim_oh) | ({WAYS{state == WRITE}} & hit_way);

    assign rd_addr = uncached ? {paddr[31:2], 2'b00} : {paddr[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign rd_line = !uncached;

    assign wb_addr = uncached ? {paddr[31:2], 2'b00} :
                     {victim_tag.tag, idx, {OFFSET_W{1'b0}}};
    assign wb_line = !uncached;
    assign wb_data = uncached ? {96'b0, req_wdata} : victim_line;
    assign wb_strb = uncached ? req_wstrb : 4'hf;

    assign d_data_ok = (state == LOOKUP && hit) || unc_done;
    assign d_rdata   = (state == LOOKUP) ? hit_word : unc_rdata;

    always_ff @(posedge clk) begin
        if (state == UNCACHED && rd_req && rd_ack) begin
            unc_rdata <= rd_data[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            init_busy <= 1'b1;
            init_cnt  <= '0;
            rd_req    <= 1'b0;
            wb_req    <= 1'b0;
            unc_done  <= 1'b0;
            victim_oh <= '0;
            lru       <= '0;
            dirty     <= '{default: '0};
        end else begin
            unc_done <= 1'b0;
            if (init_busy) begin
                init_cnt <= init_cnt + 1'b1;
                if (&init_cnt) begin
                    init_busy <= 1'b0;
                end
            end
            case (state)
                IDLE: begin
                    if (accept) state <= LOOKUP;
                end
                LOOKUP: begin
                    if (uncached) begin
                        state  <= UNCACHED;
                        wb_req <= req_op;
                        rd_req <= !req_op;
                    end else if (hit) begin
                        lru[idx] <= hit_way[0];
                        if (req_op) begin
                            state <= WRITE;
                        end else if (!accept) begin
                            state <= IDLE;
                        end
                    end else begin
                        state <= MISS;
                    end
                end
                WRITE: begin
                    dirty[idx] <= dirty[idx] | hit_way;
                    state      <= IDLE;
                end
                MISS: begin
                    victim_oh <= pick_oh;
                    if (|(pick_oh & dirty[idx])) begin
                        state  <= WRITEBACK;
                        wb_req <= 1'b1;
                    end else begin
                        state  <= REFILL;
                        rd_req <= 1'b1;
                    end
                end
                WRITEBACK: begin
                    if (wb_req && wb_ack) begin
                        wb_req <= 1'b0;
                    end else if (!wb_req && !wb_ack) begin
                        state  <= REFILL;
                        rd_req <= 1'b1;
                    end
                end
                REFILL: begin
                    if (refill_we) begin
                        rd_req     <= 1'b0;
                        dirty[idx] <= dirty[idx] & ~victim_oh;
                    end else if (!rd_req && !rd_ack) begin
                        state <= LOOKUP;    // replay
                    end
                end
                UNCACHED: begin
                    if ((rd_req && rd_ack) || (wb_req && wb_ack)) begin
                        rd_req   <= 1'b0;
                        wb_req   <= 1'b0;
                        unc_done <= 1'b1;
                    end else if (!rd_req && !wb_req && !rd_ack && !wb_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- verilog/mem_interface.sv
// ##########################################################################
// memory interface for the data cache
// one-entry write buffer for victims and uncached stores, drained ahead
// of any read, both paths sharing a single four-phase memory port
// ##########################################################################

`timescale 1ns/1ps

module mem_interface
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    // read path from the cache
    input  logic  rd_req,
    input  addr_t rd_addr,
    input  logic  rd_line,
    output logic  rd_ack,
    output line_t rd_data,
    // write path from the cache
    input  logic  wb_req,
    input  addr_t wb_addr,
    input  logic  wb_line,
    input  line_t wb_data,
    input  strb_t wb_strb,
    output logic  wb_ack,
    // memory port
    output logic  mem_req,
    output logic  mem_we,
    output logic  mem_line,
    output addr_t mem_addr,
    output line_t mem_wdata,
    output strb_t mem_wstrb,
    input  logic  mem_ack,
    input  line_t mem_rdata
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_WRITE,
        M_READ
    } mem_state_t;

    mem_state_t mstate;

    logic  buf_valid;
    addr_t buf_addr;
    logic  buf_line;
    line_t buf_data;
    strb_t buf_strb;

    // fields follow the active transfer, both sources hold them stable
    assign mem_addr  = mem_we ? buf_addr : rd_addr;
    assign mem_line  = mem_we ? buf_line : rd_line;
    assign mem_wdata = buf_data;
    assign mem_wstrb = buf_strb;

    always_ff @(posedge clk) begin
        if (wb_req && !wb_ack && !buf_valid) begin
            buf_addr <= wb_addr;
            buf_line <= wb_line;
            buf_data <= wb_data;
            buf_strb <= wb_strb;
        end
        if (mstate == M_READ && mem_req && mem_ack) begin
            rd_data <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstate    <= M_IDLE;
            buf_valid <= 1'b0;
            wb_ack    <= 1'b0;
            rd_ack    <= 1'b0;
            mem_req   <= 1'b0;
            mem_we    <= 1'b0;
        end else begin
            // cache side write handshake, acked as soon as captured
            if (wb_req && !wb_ack && !buf_valid) begin
                buf_valid <= 1'b1;
                wb_ack    <= 1'b1;
            end else if (!wb_req && wb_ack) begin
                wb_ack <= 1'b0;
            end

            case (mstate)
                M_IDLE: begin
                    if (buf_valid) begin    // drain before any read
                        mstate  <= M_WRITE;
                        mem_req <= 1'b1;
                        mem_we  <= 1'b1;
                    end else if (rd_req && !rd_ack) begin
                        mstate  <= M_READ;
                        mem_req <= 1'b1;
                        mem_we  <= 1'b0;
                    end
                end
                M_WRITE: begin
                    if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                    end else if (!mem_req && !mem_ack) begin
                        buf_valid <= 1'b0;
                        mem_we    <= 1'b0;
                        mstate    <= M_IDLE;
                    end
                end
                M_READ: begin
                    if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                        rd_ack  <= 1'b1;
                    end else if (!mem_req && !mem_ack && !rd_req) begin
                        rd_ack <= 1'b0;
                        mstate <= M_IDLE;
                    end
                end
                default: mstate <= M_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/dcache_top.sv
// ##########################################################################
// data cache top level
// cache controller joined to its memory interface
// ##########################################################################

`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  d_valid,
    input  logic  d_op,
    input  addr_t d_addr,
    input  word_t d_wdata,
    input  strb_t d_wstrb,
    output logic  d_addr_ok,
    output logic  d_data_ok,
    output word_t d_rdata,
    output logic  mem_req,
    output logic  mem_we,
    output logic  mem_line,
    output addr_t mem_addr,
    output line_t mem_wdata,
    output strb_t mem_wstrb,
    input  logic  mem_ack,
    input  line_t mem_rdata
);

    logic  rd_req;
    addr_t rd_addr;
    logic  rd_line;
    logic  rd_ack;
    line_t rd_data;

    logic  wb_req;
    addr_t wb_addr;
    logic  wb_line;
    line_t wb_data;
    strb_t wb_strb;
    logic  wb_ack;

    dcache u_dcache (
        .clk       (clk),
        .reset     (reset),
        .d_valid   (d_valid),
        .d_op      (d_op),
        .d_addr    (d_addr),
        .d_wdata   (d_wdata),
        .d_wstrb   (d_wstrb),
        .d_addr_ok (d_addr_ok),
        .d_data_ok (d_data_ok),
        .d_rdata   (d_rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_line   (rd_line),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .wb_req    (wb_req),
        .wb_addr   (wb_addr),
        .wb_line   (wb_line),
        .wb_data   (wb_data),
        .wb_strb   (wb_strb),
        .wb_ack    (wb_ack)
    );

    mem_interface u_mem_interface (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_line   (rd_line),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .wb_req    (wb_req),
        .wb_addr   (wb_addr),
        .wb_line   (wb_line),
        .wb_data   (wb_data),
        .wb_strb   (wb_strb),
        .wb_ack    (wb_ack),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_line  (mem_line),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- tests/mem_model.sv
// ##########################################################################
// behavioral memory for the data cache testbench
// answers the four-phase port after a random delay of 0 to 7 cycles
// ##########################################################################

`timescale 1ns/1ps

module mem_model
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  mem_req,
    input  logic  mem_we,
    input  logic  mem_line,
    input  addr_t mem_addr,
    input  line_t mem_wdata,
    input  strb_t mem_wstrb,
    output logic  mem_ack,
    output line_t mem_rdata
);

    word_t       words [addr_t];    // only written words live here
    logic [15:0] lfsr;

    function automatic word_t peek_word(input addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (words.exists(wa)) begin
            return words[wa];
        end
        return wa ^ 32'h5a5a_5a5a;
    endfunction

    function automatic line_t peek_line(input addr_t a);
        addr_t base;
        base = {a[31:4], 4'h0};
        return {peek_word(base + 12), peek_word(base + 8), peek_word(base + 4), peek_word(base)};
    endfunction

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_delay(output int d);
        d = 0;
        for (int i = 0; i < 3; i++) begin
            d    = (d << 1) | lfsr[15];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic do_access();
        addr_t wa;
        word_t w;
        wa = {mem_addr[31:2], 2'b00};
        if (mem_we && mem_line) begin
            for (int i = 0; i < 4; i++) begin
                words[{mem_addr[31:4], 4'h0} + 4*i] = mem_wdata[32*i +: 32];
            end
        end else if (mem_we) begin
            w = peek_word(wa);
            for (int b = 0; b < 4; b++) begin
                if (mem_wstrb[b]) w[8*b +: 8] = mem_wdata[8*b +: 8];
            end
            words[wa] = w;
        end else if (mem_line) begin
            mem_rdata <= peek_line(mem_addr);
        end else begin
            mem_rdata <= {96'b0, peek_word(wa)};
        end
    endtask

    initial begin
        int delay;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        lfsr      = 16'd43724;
        forever begin
            @(posedge clk);
            if (mem_req && !mem_ack) begin
                take_delay(delay);
                repeat (delay) @(posedge clk);
                do_access();
                mem_ack <= 1'b1;
                do @(posedge clk); while (mem_req);
                mem_ack <= 1'b0;
            end
        end
    end

endmodule

//--- tests/dcache_tb.sv
// ##########################################################################
// data cache testbench
// table of loads and stores with expected data, checked in request order
// ##########################################################################

`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int MAX_ENTRIES = 64;

    logic  clk;
    logic  reset;
    logic  d_valid;
    logic  d_op;
    addr_t d_addr;
    word_t d_wdata;
    strb_t d_wstrb;
    logic  d_addr_ok;
    logic  d_data_ok;
    word_t d_rdata;
    logic  mem_req;
    logic  mem_we;
    logic  mem_line;
    addr_t mem_addr;
    line_t mem_wdata;
    strb_t mem_wstrb;
    logic  mem_ack;
    line_t mem_rdata;

    // stimulus table
    logic  t_op    [MAX_ENTRIES];
    addr_t t_addr  [MAX_ENTRIES];
    word_t t_wdata [MAX_ENTRIES];
    strb_t t_wstrb [MAX_ENTRIES];
    word_t t_exp   [MAX_ENTRIES];
    logic  t_hit   [MAX_ENTRIES];    // answer expected one cycle after acceptance
    int    accept_cyc [MAX_ENTRIES];
    int    n_entries;
    int    n_accepted;
    int    resp_idx;
    int    cycle;
    int    limit;

    word_t ref_mem [addr_t];

    dcache_top uut (.*);

    mem_model mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic addr_t to_phys(input addr_t va);
        if (va[31:30] == 2'b10) return {3'b000, va[28:0]};    // both kseg0 and kseg1
        return va;
    endfunction

    function automatic word_t ref_read(input addr_t pa);
        addr_t wa;
        wa = {pa[31:2], 2'b00};
        if (ref_mem.exists(wa)) return ref_mem[wa];
        return wa ^ 32'h5a5a_5a5a;
    endfunction

    task automatic add_load(input addr_t va, input logic hit);
        t_op[n_entries]    = 1'b0;
        t_addr[n_entries]  = va;
        t_wdata[n_entries] = '0;
        t_wstrb[n_entries] = '0;
        t_exp[n_entries]   = ref_read(to_phys(va));
        t_hit[n_entries]   = hit;
        n_entries++;
    endtask

    task automatic add_store(input addr_t va, input word_t data, input strb_t strb,
                             input logic hit);
        word_t w;
        addr_t pa;
        pa = to_phys(va);
        w  = ref_read(pa);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
        end
        ref_mem[{pa[31:2], 2'b00}] = w;
        t_op[n_entries]    = 1'b1;
        t_addr[n_entries]  = va;
        t_wdata[n_entries] = data;
        t_wstrb[n_entries] = strb;
        t_exp[n_entries]   = '0;
        t_hit[n_entries]   = hit;
        n_entries++;
    endtask

    function automatic line_t ref_line(input addr_t pa);
        addr_t base;
        base = {pa[31:4], 4'h0};
        return {ref_read(base + 12), ref_read(base + 8), ref_read(base + 4), ref_read(base)};
    endfunction

    task automatic check_word(input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAILED d_rdata expected %h actual %h", expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_line(input line_t expected, input line_t actual);
        if (actual !== expected) begin
            $display("FAILED mem line expected %h actual %h", expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic drive_entry(input int i);
        d_valid <= 1'b1;
        d_op    <= t_op[i];
        d_addr  <= t_addr[i];
        d_wdata <= t_wdata[i];
        d_wstrb <= t_wstrb[i];
    endtask

    task automatic build_table();
        n_entries = 0;
        // misses then hits on one line
        add_load(32'h8000_0100, 1'b0);
        add_load(32'h8000_0104, 1'b1);
        add_load(32'h8000_0108, 1'b1);
        add_load(32'h8000_010c, 1'b1);
        // byte, halfword and word stores
        add_store(32'h8000_0104, 32'h0000_cd00, 4'b0010, 1'b1);
        add_store(32'h8000_0108, 32'hbeef_0000, 4'b1100, 1'b1);
        add_store(32'h8000_010c, 32'h1234_5678, 4'b1111, 1'b1);
        add_load(32'h8000_0104, 1'b1);
        add_load(32'h8000_0108, 1'b1);
        add_load(32'h8000_010c, 1'b1);
        // same set, dirty line evicted by the third
        add_load(32'h8000_1100, 1'b0);
        add_load(32'h0000_2104, 1'b0);
        add_load(32'h8000_0104, 1'b0);
        add_load(32'h8000_0108, 1'b1);
        // uncached space
        add_store(32'ha000_0200, 32'hcafe_f00d, 4'b1111, 1'b0);
        add_load(32'ha000_0200, 1'b0);
        add_store(32'ha000_0204, 32'h0077_0000, 4'b0100, 1'b0);
        add_load(32'ha000_0204, 1'b0);
        add_load(32'h8000_0204, 1'b0);
        add_load(32'h8000_0200, 1'b1);
        // back-to-back hit loads
        add_load(32'h8000_0300, 1'b0);
        add_load(32'h8000_0304, 1'b1);
        add_load(32'h8000_0308, 1'b1);
        add_load(32'h8000_030c, 1'b1);
        add_load(32'h8000_0300, 1'b1);
        add_load(32'h8000_0200, 1'b1);
        add_load(32'h8000_0204, 1'b1);
        add_load(32'h8000_010c, 1'b1);
    endtask

    initial begin
        reset      = 1'b1;
        d_valid    = 1'b0;
        d_op       = 1'b0;
        d_addr     = '0;
        d_wdata    = '0;
        d_wstrb    = '0;
        cycle      = 0;
        resp_idx   = 0;
        n_accepted = 0;
        build_table();
        limit = n_entries * 80 + 256 + 16;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        do @(posedge clk); while (!d_addr_ok);    // init sweep
        drive_entry(0);
        for (int i = 0; i < n_entries; i++) begin
            do @(posedge clk); while (!d_addr_ok);
            accept_cyc[i] = cycle;
            if (i + 1 < n_entries) begin
                drive_entry(i + 1);
            end else begin
                d_valid <= 1'b0;
            end
        end
    end

    // requests taken by the DUT
    always @(posedge clk) begin
        if (!reset && d_valid && d_addr_ok) begin
            n_accepted <= n_accepted + 1;
        end
    end

    // responses in request order
    always @(posedge clk) begin
        if (!reset && d_data_ok) begin
            if (resp_idx >= n_accepted) begin
                $display("d_data_ok seen with no request outstanding");
                $display("ERRORS FOUND");
                $fatal(1);
            end else if (t_hit[resp_idx] && cycle - accept_cyc[resp_idx] != 1) begin
                $display("FAILED d_data_ok latency expected %h actual %h", 1,
                         cycle - accept_cyc[resp_idx]);
                $display("ERRORS FOUND");
                $fatal(1);
            end else begin
                if (!t_op[resp_idx]) begin
                    check_word(t_exp[resp_idx], d_rdata);
                end
                resp_idx++;
                if (resp_idx == n_entries) begin
                    check_line(ref_line(32'h0000_0100), mem.peek_line(32'h0000_0100));
                    check_line(ref_line(32'h0000_0200), mem.peek_line(32'h0000_0200));
                    $display("NO ERRORS");
                    $finish;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (cycle > limit) begin
            $display("timeout, responses stopped after %0d of %0d requests",
                     resp_idx, n_entries);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule

//--- project.f
verilog/dcache_pkg.sv
verilog/cache_ram.sv
verilog/dcache.sv
verilog/mem_interface.sv
verilog/dcache_top.sv
tests/mem_model.sv
tests/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/cache_ram.sv
  - verilog/dcache.sv
  - verilog/mem_interface.sv
  - verilog/dcache_top.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/dcache_tb.sv
